/* verilog/daq_pkg.sv */
// shared types and constants for the multimeter control core
// register map, mode codes, output word layout and spi frame format
// imported by every block that decodes registers or builds the output word

package daq_pkg;

  // default width of the precharge and aperture clock counters
  localparam int CNT_W_DEF = 24;

  typedef logic [31:0] reg_word_t;
  typedef logic [6:0]  reg_addr_t;

  ////////////////////////////////////////
  // register map

  localparam reg_addr_t REG_MODE      = 7'd1;
  localparam reg_addr_t REG_DIRECT    = 7'd2;
  localparam reg_addr_t REG_STATUS    = 7'd3;   // read only
  localparam reg_addr_t REG_SEQ_N     = 7'd4;   // entries - 1
  localparam reg_addr_t REG_SEQ0      = 7'd5;   // first of four table words
  localparam reg_addr_t REG_SEQ1      = 7'd6;
  localparam reg_addr_t REG_SEQ2      = 7'd7;
  localparam reg_addr_t REG_SEQ3      = 7'd8;
  localparam reg_addr_t REG_PRECHARGE = 7'd9;   // clk count of the precharge phase
  localparam reg_addr_t REG_APERTURE  = 7'd10;  // clk count of the aperture, minus 1

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;  // lets the host see the bitstream is alive

  // output function select, unknown codes behave as all low
  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,
    MODE_LO       = 3'd1,
    MODE_HI       = 3'd2,
    MODE_PATTERN  = 3'd3,
    MODE_SEQ_MOCK = 3'd6
  } mode_e;

  // one row of the sequence table
  typedef struct packed {
    logic [1:0] pc_sw;   // precharge switches
    logic [3:0] azmux;   // az mux select
  } seq_entry_t;

  ////////////////////////////////////////
  // output word, msb first

  typedef struct packed {
    logic [6:0] spare_hi;
    logic       meas_complete;  // bit 24
    logic [1:0] spare_mid;
    logic [3:0] azmux;          // bits 21..18
    logic [1:0] pc_sw;          // bits 17..16
    logic [7:0] monitor;        // bits 15..8
    logic [3:0] leds;           // bits 7..4
    logic [3:0] spare_lo;
  } out_fields_t;

  // direct and pattern modes fill raw, sequence mode fills fields
  typedef union packed {
    reg_word_t   raw;
    out_fields_t fields;
  } out_word_u;

  // header byte {wr, addr} followed by 32 data bits
  typedef struct packed {
    logic      wr;
    reg_addr_t addr;
    reg_word_t data;
  } spi_frame_t;

endpackage

/* verilog/spi_frontend.sv */
// spi slave, mode 0, msb first, oversampled on the system clock
// assembles {wr, addr, data} frames and shifts read data out on sdo
// a frame is emitted only when ss rises after exactly 40 bits

`timescale 1ns/1ps

module spi_frontend (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  sck_i,
  input  logic                  ss_i,        // active low
  input  logic                  sdi_i,
  output logic                  sdo_o,
  output daq_pkg::reg_addr_t    rd_addr_o,
  input  daq_pkg::reg_word_t    rd_data_i,
  output logic                  frame_valid_o,
  output daq_pkg::spi_frame_t   frame_o
);

  import daq_pkg::*;

  localparam int FRAME_BITS = $bits(spi_frame_t);              // 40
  localparam int HDR_BITS   = FRAME_BITS - $bits(reg_word_t);  // 8

  logic [2:0] sck_q;      // two sync stages plus one for edge detect
  logic [2:0] ss_q;
  logic [1:0] sdi_q;

  logic sck_rise;
  logic sck_fall;
  logic ss_rise;
  logic ss_act;           // slave selected, synchronized

  logic [5:0]             bit_cnt_q;  // saturates, so long frames never alias to 40
  logic [FRAME_BITS-1:0]  shift_q;
  reg_addr_t              rd_addr_q;
  reg_word_t              tx_q;
  logic                   tx_act_q;   // read data being shifted out

  ////////////////////////////////////////
  // pin synchronizers

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sck_q <= '0;
      ss_q  <= '1;        // deselected
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[1:0], ss_i};
    end
  end

  always_ff @(posedge clk) begin
    sdi_q <= {sdi_q[0], sdi_i};   // aligned with sck_q[1]
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_rise  = ss_q[1] & ~ss_q[2];
  assign ss_act   = ~ss_q[1];

  ////////////////////////////////////////
  // bit count, header decode, frame out

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bit_cnt_q     <= '0;
      tx_act_q      <= 1'b0;
      frame_valid_o <= 1'b0;
    end else begin
      frame_valid_o <= ss_rise && (bit_cnt_q == 6'(FRAME_BITS));
      if (!ss_act) begin
        bit_cnt_q <= '0;
        tx_act_q  <= 1'b0;
      end else begin
        if (sck_rise && bit_cnt_q != '1)
          bit_cnt_q <= bit_cnt_q + 6'd1;
        // first falling edge after the header, reads only
        if (sck_fall && bit_cnt_q == 6'(HDR_BITS) && !shift_q[HDR_BITS-1])
          tx_act_q <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (ss_act && sck_rise) begin
      shift_q <= {shift_q[FRAME_BITS-2:0], sdi_q[1]};
      if (bit_cnt_q == 6'(HDR_BITS - 1))
        rd_addr_q <= {shift_q[HDR_BITS-3:0], sdi_q[1]};  // last header bit completes addr
    end
    if (sck_fall) begin
      if (bit_cnt_q == 6'(HDR_BITS))
        tx_q <= rd_data_i;                 // bank answered from rd_addr_q by now
      else
        tx_q <= {tx_q[30:0], 1'b1};
    end
    if (ss_rise)
      frame_o <= spi_frame_t'(shift_q);
  end

  assign rd_addr_o = rd_addr_q;

  // idle high, gated by the raw ss pin so it parks as soon as the host deselects
  assign sdo_o = (ss_i || !tx_act_q) ? 1'b1 : tx_q[31];

endmodule

/* verilog/register_bank.sv */
// control register bank behind the spi frontend
// one frame per cycle, writes land in the register the cycle after frame_valid
// reads are combinational from the address latched after the header

`timescale 1ns/1ps

module register_bank #(
  parameter int CNT_W = daq_pkg::CNT_W_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  frame_valid_i,
  input  daq_pkg::spi_frame_t   frame_i,
  input  daq_pkg::reg_addr_t    rd_addr_i,
  output daq_pkg::reg_word_t    rd_data_o,
  input  logic [3:0]            hw_flags_i,
  output daq_pkg::mode_e        mode_o,
  output daq_pkg::reg_word_t    direct_o,
  output logic [1:0]            seq_n_o,
  output daq_pkg::seq_entry_t   seq_o [4],
  output logic [CNT_W-1:0]      precharge_o,
  output logic [CNT_W-1:0]      aperture_o
);

  import daq_pkg::*;

  // full words kept so every register reads back as written
  reg_word_t mode_q;
  reg_word_t direct_q;
  reg_word_t seq_n_q;
  reg_word_t seq_q [4];
  reg_word_t precharge_q;
  reg_word_t aperture_q;

  reg_word_t status_w;
  reg_addr_t wr_seq_off;   // table row of a write
  reg_addr_t rd_seq_off;   // table row of a read

  assign wr_seq_off = frame_i.addr - REG_SEQ0;
  assign rd_seq_off = rd_addr_i - REG_SEQ0;

  assign status_w = {20'b0, hw_flags_i, STATUS_MAGIC};  // flags in 11..8

  ////////////////////////////////////////
  // write side

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mode_q      <= '0;   // direct mode, all outputs low
      direct_q    <= '0;
      seq_n_q     <= '0;
      precharge_q <= '0;
      aperture_q  <= '0;
      for (int i = 0; i < 4; i++)
        seq_q[i] <= '0;
    end else if (frame_valid_i && frame_i.wr) begin
      case (frame_i.addr)
        REG_MODE:      mode_q      <= frame_i.data;
        REG_DIRECT:    direct_q    <= frame_i.data;
        REG_SEQ_N:     seq_n_q     <= frame_i.data;
        REG_SEQ0, REG_SEQ1, REG_SEQ2, REG_SEQ3:
                       seq_q[wr_seq_off[1:0]] <= frame_i.data;
        REG_PRECHARGE: precharge_q <= frame_i.data;
        REG_APERTURE:  aperture_q  <= frame_i.data;
        default: ;     // status and unmapped, dropped
      endcase
    end
  end

  ////////////////////////////////////////
  // read side

  always_comb begin
    case (rd_addr_i)
      REG_MODE:      rd_data_o = mode_q;
      REG_DIRECT:    rd_data_o = direct_q;
      REG_STATUS:    rd_data_o = status_w;
      REG_SEQ_N:     rd_data_o = seq_n_q;
      REG_SEQ0, REG_SEQ1, REG_SEQ2, REG_SEQ3:
                     rd_data_o = seq_q[rd_seq_off[1:0]];
      REG_PRECHARGE: rd_data_o = precharge_q;
      REG_APERTURE:  rd_data_o = aperture_q;
      default:       rd_data_o = '0;
    endcase
  end

  // field views for the datapath
  assign mode_o      = mode_e'(mode_q[2:0]);
  assign direct_o    = direct_q;
  assign seq_n_o     = seq_n_q[1:0];
  assign precharge_o = precharge_q[CNT_W-1:0];
  assign aperture_o  = aperture_q[CNT_W-1:0];

  always_comb begin
    for (int i = 0; i < 4; i++)
      seq_o[i] = seq_entry_t'(seq_q[i][5:0]);   // {pc_sw, azmux}
  end

endmodule

/* verilog/sequence_acquisition.sv */
// sequence controller, walks the az/precharge table one step per measurement
// each step holds a precharge phase then releases the adc for one aperture
// period per step is precharge + aperture + 2 clocks

`timescale 1ns/1ps

module sequence_acquisition #(
  parameter int CNT_W = daq_pkg::CNT_W_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  run_i,
  input  logic [1:0]            seq_n_i,       // last entry index
  input  daq_pkg::seq_entry_t   seq_i [4],
  input  logic [CNT_W-1:0]      precharge_i,
  input  logic                  measure_valid_i,
  output logic                  adc_reset_n_o,
  output daq_pkg::seq_entry_t   step_o,
  output logic [1:0]            step_idx_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRECHARGE,
    ST_APERTURE
  } state_e;

  state_e           state_q;
  logic [CNT_W-1:0] phase_cnt_q;   // cycles spent in precharge, from 1
  logic [1:0]       idx_q;
  logic             adc_rst_n_q;

  ////////////////////////////////////////
  // state machine

  always_ff @(posedge clk) begin
    if (!rst_n_i || !run_i) begin
      state_q     <= ST_IDLE;      // dropping run restarts at step 0
      phase_cnt_q <= '0;
      idx_q       <= '0;
      adc_rst_n_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          state_q     <= ST_PRECHARGE;
          phase_cnt_q <= CNT_W'(1);
        end

        ST_PRECHARGE: begin
          // a zero count still gives one cycle, so the adc always sees reset
          if (phase_cnt_q >= precharge_i) begin
            state_q     <= ST_APERTURE;
            adc_rst_n_q <= 1'b1;         // release adc
          end else begin
            phase_cnt_q <= phase_cnt_q + CNT_W'(1);
          end
        end

        ST_APERTURE: begin
          if (measure_valid_i) begin   // one measurement in flight only
            state_q     <= ST_PRECHARGE;
            phase_cnt_q <= CNT_W'(1);
            adc_rst_n_q <= 1'b0;
            idx_q       <= (idx_q >= seq_n_i) ? 2'd0 : idx_q + 2'd1;
          end
        end

        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign adc_reset_n_o = adc_rst_n_q;
  assign step_o        = seq_i[idx_q];   // held through precharge and aperture
  assign step_idx_o    = idx_q;

endmodule

/* verilog/adc_mock.sv */
// stand-in for the adc modulator
// counts aperture + 1 clocks after reset release, then flags one valid cycle

`timescale 1ns/1ps

module adc_mock #(
  parameter int CNT_W = daq_pkg::CNT_W_DEF
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             adc_reset_n_i,    // low holds idle
  input  logic [CNT_W-1:0] aperture_i,
  output logic             measure_valid_o
);

  logic [CNT_W-1:0] cnt_q;
  logic             done_q;   // one valid per release

  always_ff @(posedge clk) begin
    if (!rst_n_i || !adc_reset_n_i) begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (!done_q) begin
        if (cnt_q == aperture_i) begin
          measure_valid_o <= 1'b1;
          done_q          <= 1'b1;
        end else begin
          cnt_q <= cnt_q + CNT_W'(1);   // integrating
        end
      end
    end
  end

endmodule

/* verilog/output_mux.sv */
// mode select for the output word, plus the free running test pattern
// the selected word is registered, so pins follow a change one clock later

`timescale 1ns/1ps

module output_mux (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  daq_pkg::mode_e        mode_i,
  input  daq_pkg::reg_word_t    direct_i,
  input  daq_pkg::seq_entry_t   step_i,
  input  logic [1:0]            step_idx_i,
  input  logic                  measure_valid_i,
  input  logic                  adc_reset_n_i,
  output daq_pkg::out_word_u    out_o
);

  import daq_pkg::*;

  reg_word_t pattern_q;   // leds field steps every 16 clocks
  out_word_u seq_w;
  out_word_u sel_w;

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      pattern_q <= '0;
    else
      pattern_q <= pattern_q + 32'd1;
  end

  ////////////////////////////////////////
  // sequence mode word

  always_comb begin
    seq_w                      = '0;
    seq_w.fields.azmux         = step_i.azmux;
    seq_w.fields.pc_sw         = step_i.pc_sw;
    seq_w.fields.monitor       = {4'b0, measure_valid_i, adc_reset_n_i, step_idx_i};
    seq_w.fields.meas_complete = measure_valid_i;
    seq_w.fields.leds          = 4'b0001 << step_idx_i;   // one-hot step
  end

  always_comb begin
    case (mode_i)
      MODE_DIRECT:   sel_w.raw = direct_i;
      MODE_HI:       sel_w.raw = '1;
      MODE_PATTERN:  sel_w.raw = pattern_q;
      MODE_SEQ_MOCK: sel_w     = seq_w;
      default:       sel_w.raw = '0;     // MODE_LO and unused codes
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      out_o <= '0;
    else
      out_o <= sel_w;
  end

endmodule

/* verilog/top.sv */
// multimeter front-end control core, board level top
// spi register access, mode output mux and mocked sequence acquisition
// all logic runs on CLK, the spi pins are oversampled

`timescale 1ns/1ps

module top #(
  parameter int CNT_W = daq_pkg::CNT_W_DEF   // precharge and aperture counter width
) (
  input  logic       CLK,
  input  logic       rst_n_i,
  input  logic       SCK,
  input  logic       SS,
  input  logic       SDI,
  output logic       SDO,
  input  logic [3:0] hw_flags_i,
  input  logic       trigger_source_internal_i,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic       meas_complete_o
);

  import daq_pkg::*;

  reg_addr_t  rd_addr;
  reg_word_t  rd_data;
  logic       frame_valid;
  spi_frame_t frame;

  mode_e            mode;
  reg_word_t        direct;
  logic [1:0]       seq_n;
  seq_entry_t       seq_tab [4];
  logic [CNT_W-1:0] precharge;
  logic [CNT_W-1:0] aperture;

  logic       seq_run;
  logic       adc_reset_n;
  logic       measure_valid;
  seq_entry_t step;
  logic [1:0] step_idx;
  out_word_u  out_w;

  ////////////////////////////////////////
  // spi and registers

  spi_frontend u_spi (
    .clk(CLK), .rst_n_i(rst_n_i),
    .sck_i(SCK), .ss_i(SS), .sdi_i(SDI), .sdo_o(SDO),
    .rd_addr_o(rd_addr), .rd_data_i(rd_data),
    .frame_valid_o(frame_valid), .frame_o(frame)
  );

  register_bank #(.CNT_W(CNT_W)) u_regs (
    .clk(CLK), .rst_n_i(rst_n_i),
    .frame_valid_i(frame_valid), .frame_i(frame),
    .rd_addr_i(rd_addr), .rd_data_o(rd_data),
    .hw_flags_i(hw_flags_i),
    .mode_o(mode), .direct_o(direct), .seq_n_o(seq_n), .seq_o(seq_tab),
    .precharge_o(precharge), .aperture_o(aperture)
  );

  // sequencer only runs in its own mode
  assign seq_run = trigger_source_internal_i && (mode == MODE_SEQ_MOCK);

  sequence_acquisition #(.CNT_W(CNT_W)) u_seq (
    .clk(CLK), .rst_n_i(rst_n_i), .run_i(seq_run),
    .seq_n_i(seq_n), .seq_i(seq_tab), .precharge_i(precharge),
    .measure_valid_i(measure_valid), .adc_reset_n_o(adc_reset_n),
    .step_o(step), .step_idx_o(step_idx)
  );

  adc_mock #(.CNT_W(CNT_W)) u_adc (
    .clk(CLK), .rst_n_i(rst_n_i), .adc_reset_n_i(adc_reset_n),
    .aperture_i(aperture), .measure_valid_o(measure_valid)
  );

  output_mux u_mux (
    .clk(CLK), .rst_n_i(rst_n_i), .mode_i(mode), .direct_i(direct),
    .step_i(step), .step_idx_i(step_idx),
    .measure_valid_i(measure_valid), .adc_reset_n_i(adc_reset_n),
    .out_o(out_w)
  );

  // pin map, spare bits have no pins
  assign leds_o          = out_w.fields.leds;
  assign monitor_o       = out_w.fields.monitor;
  assign pc_sw_o         = out_w.fields.pc_sw;
  assign azmux_o         = out_w.fields.azmux;
  assign meas_complete_o = out_w.fields.meas_complete;

endmodule

/* tests/top_chk.sv */
// concurrent assertions on the board level outputs of top
// bound into every top instance by the bind at the end of this file

`timescale 1ns/1ps

module top_chk (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           ss_i,
  input logic           sdo_i,
  input daq_pkg::mode_e mode_i,
  input logic           meas_complete_i,
  input logic [3:0]     azmux_i
);

  import daq_pkg::*;

  logic [2:0] seq_hist;     // mode was sequence, last three clocks
  logic       seq_steady;   // output word settled in sequence mode

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)
      seq_hist <= '0;
    else
      seq_hist <= {seq_hist[1:0], mode_i == MODE_SEQ_MOCK};
  end

  assign seq_steady = (&seq_hist) && (mode_i == MODE_SEQ_MOCK);

  ////////////////////////////////////////
  // output protocol

  a_mc_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (seq_steady && meas_complete_i) |=> (!meas_complete_i || !seq_steady))
    else $error("meas_complete_o held high for more than one cycle");

  // az mux only moves right after a measurement completes
  a_az_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (seq_steady && !$past(meas_complete_i)) |-> $stable(azmux_i))
    else $error("azmux_o changed within a sequence step");

  // high while deselected and still high on the clock after select, read data not loaded yet
  a_sdo_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ss_i |=> sdo_i)
    else $error("sdo not high while ss is high or at the start of a frame");

endmodule

bind top top_chk u_chk (
  .clk_i(CLK),
  .rst_n_i(rst_n_i),
  .ss_i(SS),
  .sdo_i(SDO),
  .mode_i(mode),
  .meas_complete_i(meas_complete_o),
  .azmux_i(azmux_o)
);

/* tests/tb_top.sv */
// testbench for the multimeter control core top level
// drives spi frames from a stimulus table and checks readback, pins, pattern and sequencer
// inputs change on the falling clock edge, outputs are sampled there too

`timescale 1ns/1ps

module tb_top;

  import daq_pkg::*;

  localparam int         RESET_CYCLES = 16;
  localparam int         SCK_HALF     = 10;   // clk periods per sck half cycle
  localparam int         FRAME_CYCLES = (2 * 40 + 1) * SCK_HALF + 16;
  localparam logic [3:0] HW_FLAGS     = 4'h5;
  localparam int         PRE_CYCLES   = 5;
  localparam int         APER_VAL     = 7;
  localparam int         SEQ_PERIOD   = PRE_CYCLES + APER_VAL + 2;
  localparam logic [1:0] SEQ_N_RUN    = 2'd2;   // three entries in the run
  localparam int         SEQ_PULSES   = 8;

  typedef enum logic [2:0] {
    OP_WR,
    OP_RD,        // spi read, compare with exp_val
    OP_PINS,      // pins against the fields of exp_val
    OP_PATTERN,
    OP_SEQ        // data = pulses, exp_val = cycles between pulses
  } op_e;

  typedef struct packed {
    op_e       op;
    reg_addr_t addr;
    reg_word_t data;
    reg_word_t exp_val;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  logic sck;
  logic ss;
  logic sdi;
  logic sdo;
  logic [3:0] hw_flags;
  logic trig;
  logic [3:0] leds;
  logic [7:0] monitor;
  logic [1:0] pc_sw;
  logic [3:0] azmux;
  logic meas_complete;
  logic [18:0] pins;

  row_t rows [$];
  bit   rows_ready = 1'b0;
  int   seed = 43;

  always #2 clk = ~clk;   // 4 ns

  top dut (
    .CLK(clk), .rst_n_i(rst_n),
    .SCK(sck), .SS(ss), .SDI(sdi), .SDO(sdo),
    .hw_flags_i(hw_flags), .trigger_source_internal_i(trig),
    .leds_o(leds), .monitor_o(monitor), .pc_sw_o(pc_sw),
    .azmux_o(azmux), .meas_complete_o(meas_complete)
  );

  assign pins = {meas_complete, azmux, pc_sw, monitor, leds};

  ////////////////////////////////////////
  // expected value helpers

  // pin fields of a 32 bit output word, same order as pins
  function automatic logic [18:0] fields_of(input reg_word_t w);
    return {w[24], w[21:18], w[17:16], w[15:8], w[7:4]};
  endfunction

  // sequence table contents, {pc_sw, azmux}
  function automatic logic [5:0] entry_val(input logic [1:0] n);
    case (n)
      2'd0:    return 6'h13;
      2'd1:    return 6'h25;
      2'd2:    return 6'h3A;
      default: return 6'h0F;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("CHECKS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp_v, input string what);
    if (got !== exp_v) begin
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp_v);
      abort_run("value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // spi host, mode 0, msb first

  task automatic half_period();
    repeat (SCK_HALF) @(negedge clk);
  endtask

  task automatic spi_xfer(input logic wr, input reg_addr_t addr, input reg_word_t wdata,
                          output reg_word_t rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    @(negedge clk);
    ss = 1'b0;
    for (int i = 39; i >= 0; i--) begin
      sdi = frame[i];
      half_period();
      if (i < 32)
        rdata = {rdata[30:0], sdo};   // sampled just before the rising edge
      sck = 1'b1;
      half_period();
      sck = 1'b0;
    end
    half_period();
    ss  = 1'b1;
    sdi = 1'b0;
    repeat (8) @(negedge clk);        // write lands and output register follows
  endtask

  task automatic spi_write(input reg_addr_t addr, input reg_word_t data);
    reg_word_t unused;
    spi_xfer(1'b1, addr, data, unused);
  endtask

  task automatic spi_read(input reg_addr_t addr, output reg_word_t data);
    spi_xfer(1'b0, addr, '0, data);
  endtask

  ////////////////////////////////////////
  // mode checks

  task automatic pattern_check();
    logic [3:0] first;
    logic [3:0] prev;
    int         changes;
    for (int n = 0; n < 3; n++) begin
      first   = leds;
      prev    = leds;
      changes = 0;
      repeat (16) begin
        @(negedge clk);
        if (leds != prev)
          changes++;
        prev = leds;
      end
      check(32'(changes), 32'd1, "pattern leds steps once per 16 cycles");
      check(32'(leds), 32'(4'(first + 4'd1)), "pattern leds after 16 cycles");
    end
  endtask

  task automatic sequence_check(input int pulses, input int period);
    int         cyc;
    int         last_cyc;
    int         waited;
    logic [1:0] idx;
    logic [5:0] ent;
    cyc      = 0;
    last_cyc = 0;
    idx      = 2'd0;
    for (int k = 0; k < pulses; k++) begin
      waited = 0;
      @(negedge clk);
      cyc++;
      while (!meas_complete) begin
        waited++;
        if (waited > 2 * period + 16)
          abort_run("sequencer timed out, no measurement complete pulse");
        @(negedge clk);
        cyc++;
      end
      ent = entry_val(idx);
      check(32'(azmux), 32'(ent[3:0]), $sformatf("azmux at pulse %0d", k));
      check(32'(pc_sw), 32'(ent[5:4]), $sformatf("pc_sw at pulse %0d", k));
      check(32'(monitor), 32'({6'b000011, idx}), $sformatf("monitor at pulse %0d", k));
      check(32'(leds), 32'(4'b0001 << idx), $sformatf("step leds at pulse %0d", k));
      if (k > 0)
        check(32'(cyc - last_cyc), 32'(period), $sformatf("gap before pulse %0d", k));
      last_cyc = cyc;
      idx      = (idx == SEQ_N_RUN) ? 2'd0 : idx + 2'd1;   // wraps after seq_n
    end
  endtask

  ////////////////////////////////////////
  // stimulus table

  task automatic add_row(input op_e op, input reg_addr_t addr, input reg_word_t data,
                         input reg_word_t exp_v);
    rows.push_back('{op: op, addr: addr, data: data, exp_val: exp_v});
  endtask

  task automatic add_write_readback(input reg_addr_t addr, input reg_word_t data);
    add_row(OP_WR, addr, data, '0);
    add_row(OP_RD, addr, '0, data);
  endtask

  task automatic build_table();
    reg_word_t r;
    add_write_readback(REG_MODE, 32'h1234_5670);        // low bits still select direct
    add_write_readback(REG_DIRECT, 32'hDEAD_BEEF);
    add_write_readback(REG_SEQ_N, 32'h0000_0003);
    for (int i = 0; i < 4; i++)
      add_write_readback(REG_SEQ0 + 7'(i), 32'(entry_val(2'(i))));
    add_write_readback(REG_PRECHARGE, 32'(PRE_CYCLES));
    add_write_readback(REG_APERTURE, 32'(APER_VAL));
    add_row(OP_WR, REG_STATUS, 32'hFFFF_FFFF, '0);    // read only, must be ignored
    add_row(OP_RD, REG_STATUS, '0, {20'h0, HW_FLAGS, 8'hAA});
    add_row(OP_RD, 7'h40, '0, '0);                    // unmapped
    // direct mode with random words
    add_row(OP_WR, REG_MODE, 32'(MODE_DIRECT), '0);
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      add_row(OP_WR, REG_DIRECT, r, '0);
      add_row(OP_PINS, '0, '0, r);
    end
    add_row(OP_WR, REG_MODE, 32'(MODE_LO), '0);
    add_row(OP_PINS, '0, '0, 32'h0000_0000);
    add_row(OP_WR, REG_MODE, 32'(MODE_HI), '0);
    add_row(OP_PINS, '0, '0, 32'hFFFF_FFFF);
    add_row(OP_WR, REG_MODE, 32'(MODE_PATTERN), '0);
    add_row(OP_PATTERN, '0, '0, '0);
    // sequence run last, nothing writes after it
    add_row(OP_WR, REG_SEQ_N, 32'(SEQ_N_RUN), '0);
    add_row(OP_WR, REG_MODE, 32'(MODE_SEQ_MOCK), '0);
    add_row(OP_SEQ, '0, 32'(SEQ_PULSES), 32'(SEQ_PERIOD));
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    row_t      cur;
    reg_word_t rd;
    rst_n    = 1'b0;
    sck      = 1'b0;
    ss       = 1'b1;
    sdi      = 1'b0;
    hw_flags = HW_FLAGS;
    trig     = 1'b1;   // gated by the mode inside top
    build_table();
    rows_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    check(32'(pins), 32'd0, "outputs after reset");
    check(32'(sdo), 32'd1, "sdo idle after reset");
    for (int n = 0; n < rows.size(); n++) begin
      cur = rows[n];
      case (cur.op)
        OP_WR: spi_write(cur.addr, cur.data);
        OP_RD: begin
          spi_read(cur.addr, rd);
          check(rd, cur.exp_val, $sformatf("readback of register %0d", cur.addr));
        end
        OP_PINS:    check(32'(pins), 32'(fields_of(cur.exp_val)), "output pins");
        OP_PATTERN: pattern_check();
        OP_SEQ:     sequence_check(int'(cur.data), int'(cur.exp_val));
        default:    abort_run("unknown operation in the stimulus table");
      endcase
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    wait (rows_ready);
    repeat (RESET_CYCLES + rows.size() * FRAME_CYCLES + 2 * SEQ_PULSES * SEQ_PERIOD + 500)
      @(posedge clk);
    abort_run("watchdog timeout, the test did not finish in time");
  end

endmodule

/* verilog.f */
verilog/daq_pkg.sv
verilog/spi_frontend.sv
verilog/register_bank.sv
verilog/sequence_acquisition.sv
verilog/adc_mock.sv
verilog/output_mux.sv
verilog/top.sv
tests/top_chk.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator, verdict from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f verilog.f -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
